// File: logic/usb_stream_pkg.sv
`default_nettype none

package usb_stream_pkg;

  // Payload and endpoint widths
  typedef logic [7:0] byte_t;
  typedef logic [3:0] endpt_t;

  // One stream beat; valid and ready travel beside it
  typedef struct packed {
    byte_t tdata;
    logic  tlast;  // Last byte of the packet
  } axis_beat_t;

  // Bulk IN endpoints served by this bridge
  localparam endpt_t USER_ENDPOINT = 4'd1;
  localparam endpt_t TELE_ENDPOINT = 4'd2;

endpackage

`default_nettype wire

// File: logic/telemetry_pkg.sv
`default_nettype none

package telemetry_pkg;

  // One logged copy of the core state byte
  typedef logic [7:0] tele_record_t;

  // Largest recorder FIFO the level type can describe
  localparam int unsigned TELE_DEPTH_MAX = 64;

  // Fill count, 0 to TELE_DEPTH_MAX inclusive
  typedef logic [$clog2(TELE_DEPTH_MAX + 1)-1:0] tele_level_t;

endpackage

`default_nettype wire

// File: logic/reset_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module reset_sequencer (
  input  wire  clock,
  input  wire  areset_n,
  input  wire  usb_bus_reset_i,
  output logic phy_reset_n_o,
  output logic usb_reset_o
);

  logic [3:0] stage_q;  // Release chain, stage 0 first

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      stage_q <= '0;
    end else begin
      stage_q[2:0] <= {stage_q[1:0], 1'b1};
      stage_q[3]   <= stage_q[2] & ~usb_bus_reset_i;  // Bus reset pulls the core back
    end
  end

  assign phy_reset_n_o = stage_q[1];
  assign usb_reset_o   = ~stage_q[3];

  // The core must never leave reset before the PHY does
  core_after_phy: assert property (
    @(posedge clock) disable iff (!areset_n)
    !phy_reset_n_o |-> usb_reset_o
  );

endmodule

`default_nettype wire

// File: logic/in_source_select.sv
`timescale 1ns/10ps
`default_nettype none

module in_source_select
  import usb_stream_pkg::*, telemetry_pkg::*;
#(
  parameter int unsigned TELE_READY_LEVEL = 4
) (
  input  wire         clock,
  input  wire         areset_n,
  input  wire         reset_i,
  input  endpt_t      blk_endpt_i,
  input  wire         blk_in_ready_i,
  input  tele_level_t tele_level_i,
  input  wire         s_valid_i,
  input  axis_beat_t  s_beat_i,
  output logic        s_ready_o,
  input  wire         tele_valid_i,
  input  axis_beat_t  tele_beat_i,
  output logic        tele_ready_o,
  output logic        tele_sel_o,
  output logic        blk_in_ready_o,
  output logic        mux_valid_o,
  output axis_beat_t  mux_beat_o,
  input  wire         mux_ready_i
);

  logic tele_sel_q;
  logic blk_in_ready_q;

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      tele_sel_q     <= 1'b0;
      blk_in_ready_q <= 1'b0;
    end else if (reset_i) begin
      tele_sel_q     <= 1'b0;
      blk_in_ready_q <= 1'b0;
    end else begin
      tele_sel_q     <= blk_endpt_i == TELE_ENDPOINT;
      // Enough telemetry queued counts as data to send
      blk_in_ready_q <= blk_in_ready_i ||
                        tele_level_i >= tele_level_t'(TELE_READY_LEVEL);
    end
  end

  assign tele_sel_o     = tele_sel_q;
  assign blk_in_ready_o = blk_in_ready_q;

  // 2:1 steering of the bulk IN stream
  assign mux_valid_o  = tele_sel_q ? tele_valid_i : s_valid_i;
  assign mux_beat_o   = tele_sel_q ? tele_beat_i : s_beat_i;
  assign s_ready_o    = ~tele_sel_q & mux_ready_i;
  assign tele_ready_o = tele_sel_q & mux_ready_i;

  only_one_source: assert property (
    @(posedge clock) disable iff (!areset_n)
    !(s_ready_o && tele_ready_o)
  );

endmodule

`default_nettype wire

// File: logic/axis_skid_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module axis_skid_buffer
  import usb_stream_pkg::*;
(
  input  wire        clock,
  input  wire        areset_n,
  input  wire        reset_i,
  input  wire        s_valid_i,
  input  axis_beat_t s_beat_i,
  output logic       s_ready_o,
  output logic       m_valid_o,
  output axis_beat_t m_beat_o,
  input  wire        m_ready_i
);

  axis_beat_t out_q, skid_q;
  logic out_valid_q, skid_valid_q, ready_q;
  logic out_valid_d, skid_valid_d;
  logic accept, out_free, load_out, load_skid, skid_to_out;

  assign accept   = s_valid_i && ready_q;
  assign out_free = !out_valid_q || m_ready_i;  // Output register drains this cycle

  always_comb begin
    out_valid_d  = out_valid_q;
    skid_valid_d = skid_valid_q;
    load_out     = 1'b0;
    load_skid    = 1'b0;
    skid_to_out  = 1'b0;
    if (out_free) begin
      if (skid_valid_q) begin
        // Older beat first; input is stalled while the skid is full
        skid_to_out  = 1'b1;
        out_valid_d  = 1'b1;
        skid_valid_d = 1'b0;
      end else begin
        out_valid_d = accept;
        load_out    = accept;
      end
    end else if (accept) begin
      skid_valid_d = 1'b1;
      load_skid    = 1'b1;
    end
  end

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      out_valid_q  <= 1'b0;
      skid_valid_q <= 1'b0;
      ready_q      <= 1'b0;
    end else if (reset_i) begin
      out_valid_q  <= 1'b0;
      skid_valid_q <= 1'b0;
      ready_q      <= 1'b0;
    end else begin
      out_valid_q  <= out_valid_d;
      skid_valid_q <= skid_valid_d;
      ready_q      <= !skid_valid_d;  // Low only with both entries full
    end
  end

  always_ff @(posedge clock) begin
    if (skid_to_out) begin
      out_q <= skid_q;
    end else if (load_out) begin
      out_q <= s_beat_i;
    end
    if (load_skid) skid_q <= s_beat_i;
  end

  assign s_ready_o = ready_q;
  assign m_valid_o = out_valid_q;
  assign m_beat_o  = out_q;

  hold_under_stall: assert property (
    @(posedge clock) disable iff (!areset_n || reset_i)
    m_valid_o && !m_ready_i |=> m_valid_o && $stable(m_beat_o)
  );

endmodule

`default_nettype wire

// File: logic/telemetry_recorder.sv
`timescale 1ns/10ps
`default_nettype none

module telemetry_recorder
  import usb_stream_pkg::*, telemetry_pkg::*;
#(
  parameter int unsigned TELE_DEPTH = 16
) (
  input  wire          clock,
  input  wire          areset_n,
  input  wire          reset_i,
  input  tele_record_t state_i,
  input  wire          blk_start_i,
  input  wire          tele_sel_i,
  output logic         m_valid_o,
  output axis_beat_t   m_beat_o,
  input  wire          m_ready_i,
  output tele_level_t  level_o,
  output logic         has_telemetry_o,
  output logic         overflow_o
);

  localparam int AW = $clog2(TELE_DEPTH);

  typedef logic [AW-1:0] ptr_t;
  typedef enum logic [0:0] {
    st_idle,
    st_send
  } rd_state_t;

  tele_record_t mem [TELE_DEPTH];
  tele_record_t last_q;  // Last value seen on state_i
  ptr_t         wr_ptr_q, rd_ptr_q;
  tele_level_t  level_q;
  tele_level_t  count_q;  // Records left in the current packet
  logic         overflow_q;
  rd_state_t    state_q;
  logic         full, change, push, pop;

  assign full   = level_q == tele_level_t'(TELE_DEPTH);
  assign change = state_i != last_q;
  assign push   = change && !full;
  assign pop    = m_valid_o && m_ready_i;

  always_ff @(posedge clock) begin
    if (push) mem[wr_ptr_q] <= state_i;
  end

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      last_q     <= '0;
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      level_q    <= '0;
      count_q    <= '0;
      overflow_q <= 1'b0;
      state_q    <= st_idle;
    end else if (reset_i) begin
      last_q     <= '0;
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      level_q    <= '0;
      count_q    <= '0;
      overflow_q <= 1'b0;
      state_q    <= st_idle;
    end else begin
      if (change) last_q <= state_i;
      if (change && full) overflow_q <= 1'b1;  // Sticky until reset
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      level_q <= level_q + tele_level_t'(push) - tele_level_t'(pop);

      case (state_q)
        st_idle: begin
          // Snapshot the level, later records wait for the next read
          if (blk_start_i && tele_sel_i && level_q != '0) begin
            count_q <= level_q;
            state_q <= st_send;
          end
        end
        st_send: begin
          if (pop) begin
            count_q <= count_q - 1'b1;
            if (count_q == tele_level_t'(1)) state_q <= st_idle;
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  assign m_valid_o       = state_q == st_send;
  assign m_beat_o        = '{tdata: byte_t'(mem[rd_ptr_q]),
                             tlast: count_q == tele_level_t'(1)};
  assign level_o         = level_q;
  assign has_telemetry_o = level_q != '0;
  assign overflow_o      = overflow_q;

  level_bounded: assert property (
    @(posedge clock) disable iff (!areset_n)
    level_q <= tele_level_t'(TELE_DEPTH)
  );

  no_read_when_empty: assert property (
    @(posedge clock) disable iff (!areset_n || reset_i)
    pop |-> level_q != '0
  );

endmodule

`default_nettype wire

// File: logic/bulk_in_bridge.sv
`timescale 1ns/10ps
`default_nettype none

module bulk_in_bridge
  import usb_stream_pkg::*, telemetry_pkg::*;
#(
  parameter int unsigned TELE_DEPTH       = 16,
  parameter int unsigned TELE_READY_LEVEL = 4
) (
  input  wire          clock,
  input  wire          areset_n,
  input  wire          usb_bus_reset_i,
  output logic         phy_reset_n_o,
  output logic         usb_reset_o,
  input  wire          blk_in_ready_i,
  input  wire          blk_start_i,
  input  endpt_t       blk_endpt_i,
  input  tele_record_t state_i,
  input  wire          s_axis_valid_i,
  input  axis_beat_t   s_axis_beat_i,
  output logic         s_axis_ready_o,
  output logic         blk_in_ready_o,
  output logic         has_telemetry_o,
  output logic         tele_overflow_o,
  output logic         m_axis_valid_o,
  output axis_beat_t   m_axis_beat_o,
  input  wire          m_axis_ready_i
);

  logic        tele_sel, tele_valid, tele_ready;
  logic        mux_valid, mux_ready;
  axis_beat_t  tele_beat, mux_beat;
  tele_level_t tele_level;

  reset_sequencer u_reset_seq (
    .clock           (clock),
    .areset_n        (areset_n),
    .usb_bus_reset_i (usb_bus_reset_i),
    .phy_reset_n_o   (phy_reset_n_o),
    .usb_reset_o     (usb_reset_o)
  );

  in_source_select #(
    .TELE_READY_LEVEL (TELE_READY_LEVEL)
  ) u_select (
    .clock          (clock),
    .areset_n       (areset_n),
    .reset_i        (usb_reset_o),
    .blk_endpt_i    (blk_endpt_i),
    .blk_in_ready_i (blk_in_ready_i),
    .tele_level_i   (tele_level),
    .s_valid_i      (s_axis_valid_i),
    .s_beat_i       (s_axis_beat_i),
    .s_ready_o      (s_axis_ready_o),
    .tele_valid_i   (tele_valid),
    .tele_beat_i    (tele_beat),
    .tele_ready_o   (tele_ready),
    .tele_sel_o     (tele_sel),
    .blk_in_ready_o (blk_in_ready_o),
    .mux_valid_o    (mux_valid),
    .mux_beat_o     (mux_beat),
    .mux_ready_i    (mux_ready)
  );

  axis_skid_buffer u_skid (
    .clock     (clock),
    .areset_n  (areset_n),
    .reset_i   (usb_reset_o),
    .s_valid_i (mux_valid),
    .s_beat_i  (mux_beat),
    .s_ready_o (mux_ready),
    .m_valid_o (m_axis_valid_o),
    .m_beat_o  (m_axis_beat_o),
    .m_ready_i (m_axis_ready_i)
  );

  telemetry_recorder #(
    .TELE_DEPTH (TELE_DEPTH)
  ) u_telemetry (
    .clock           (clock),
    .areset_n        (areset_n),
    .reset_i         (usb_reset_o),
    .state_i         (state_i),
    .blk_start_i     (blk_start_i),
    .tele_sel_i      (tele_sel),
    .m_valid_o       (tele_valid),
    .m_beat_o        (tele_beat),
    .m_ready_i       (tele_ready),
    .level_o         (tele_level),
    .has_telemetry_o (has_telemetry_o),
    .overflow_o      (tele_overflow_o)
  );

endmodule

`default_nettype wire

// File: testbench/bulk_in_bridge_tb.sv
`timescale 1ns/10ps
`default_nettype none

module bulk_in_bridge_tb
  import usb_stream_pkg::*, telemetry_pkg::*;
;

  localparam int TIMEOUT = 200;  // Cycles allowed for any single wait

  typedef logic [8*24-1:0] name_t;

  logic         clock;
  logic         areset_n;
  logic         bus_reset, host_ready, blk_start;
  endpt_t       blk_endpt;
  tele_record_t state;
  logic         s_valid, s_ready, m_valid, m_ready;
  axis_beat_t   s_beat, m_beat;
  logic         phy_reset_n, usb_reset, blk_in_ready, has_telemetry, tele_overflow;
  logic [31:0]  lfsr_q;
  axis_beat_t   tx_q[$];   // Beats still to send on the user stream
  axis_beat_t   exp_q[$];  // Beats expected on m_axis, in order

  bulk_in_bridge DUT (
    .clock           (clock),
    .areset_n        (areset_n),
    .usb_bus_reset_i (bus_reset),
    .phy_reset_n_o   (phy_reset_n),
    .usb_reset_o     (usb_reset),
    .blk_in_ready_i  (host_ready),
    .blk_start_i     (blk_start),
    .blk_endpt_i     (blk_endpt),
    .state_i         (state),
    .s_axis_valid_i  (s_valid),
    .s_axis_beat_i   (s_beat),
    .s_axis_ready_o  (s_ready),
    .blk_in_ready_o  (blk_in_ready),
    .has_telemetry_o (has_telemetry),
    .tele_overflow_o (tele_overflow),
    .m_axis_valid_o  (m_valid),
    .m_axis_beat_o   (m_beat),
    .m_axis_ready_i  (m_ready)
  );

  always #5 clock = ~clock;

  // Taps 32 22 2 1
  function automatic logic next_bit();
    logic fb;
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  function automatic byte_t random_byte();
    byte_t b;
    for (int i = 0; i < 8; i++) b = {b[6:0], next_bit()};
    return b;
  endfunction

  function automatic logic [31:0] flags();
    return {26'b0, usb_reset, s_ready, m_valid, blk_in_ready, has_telemetry, tele_overflow};
  endfunction

  task automatic compare(input name_t name, input logic [31:0] expected,
                         input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Fail %0s: expected %h, actual %h", name, expected, actual);
      $display("TEST RESULT: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic give_up(input name_t name, input string what);
    $display("%0s: gave up waiting for %0s", name, what);
    $display("TEST RESULT: FAIL");
    $fatal(1, "timeout");
  endtask

  task automatic send_user(input name_t name);
    int waited;
    while (tx_q.size() > 0) begin
      s_valid <= 1'b1;
      s_beat  <= tx_q[0];
      waited = 0;
      @(posedge clock);
      while (!s_ready) begin  // Valid was already high in this cycle
        if (waited == TIMEOUT) give_up(name, "s_axis_ready_o");
        waited++;
        @(posedge clock);
      end
      tx_q.delete(0);
    end
    s_valid <= 1'b0;
  endtask

  // Random back-pressure on m_axis while expected beats remain
  task automatic receive_beats(input name_t name);
    int waited;
    waited = 0;
    while (exp_q.size() > 0) begin
      @(posedge clock);
      if (m_valid && m_ready) begin
        compare(name, {23'b0, exp_q[0]}, {23'b0, m_beat});
        exp_q.delete(0);
        waited = 0;
      end else if (waited == TIMEOUT) begin
        give_up(name, "m_axis_valid_o");
      end else begin
        waited++;
      end
      m_ready <= next_bit();
    end
    m_ready <= 1'b0;
  endtask

  task automatic run_command(input name_t name, input logic [7:0] cmd,
                             input logic [31:0] op_a, input logic [31:0] op_b);
    axis_beat_t beat;
    int waited;
    waited = 0;
    case (cmd)
      "F": begin  // Levels sampled mid-cycle
        @(negedge clock);
        compare(name, op_a, flags());
        @(posedge clock);
      end
      "W": begin
        @(negedge clock);
        while (!phy_reset_n) begin
          if (waited == TIMEOUT) give_up(name, "phy_reset_n_o");
          waited++;
          @(negedge clock);
        end
        compare(name, op_a, {31'b0, usb_reset});  // Core still held when PHY is released
        waited = 0;
        while (usb_reset) begin
          if (waited == TIMEOUT) give_up(name, "usb_reset_o to fall");
          waited++;
          @(negedge clock);
        end
        @(posedge clock);
      end
      "B": begin
        bus_reset <= op_a[0];
        @(posedge clock);
        @(negedge clock);
        compare(name, op_b, {31'b0, usb_reset});
        @(posedge clock);
      end
      "E": begin
        blk_endpt <= endpt_t'(op_a);
        @(posedge clock);
      end
      "N": repeat (op_a) @(posedge clock);
      "S": begin
        state <= tele_record_t'(op_a);
        repeat (op_b) @(posedge clock);
      end
      "L": begin  // A run of distinct values, one per cycle
        for (int i = 0; i < op_b; i++) begin
          state <= tele_record_t'(op_a + i);
          @(posedge clock);
        end
      end
      "X": exp_q.push_back('{tdata: byte_t'(op_a), tlast: op_b[0]});
      "Y": begin
        for (int i = 0; i < op_b; i++) begin
          exp_q.push_back('{tdata: byte_t'(op_a + i), tlast: i == op_b - 1});
        end
      end
      "U": begin
        for (int i = 0; i < op_a; i++) begin
          beat = '{tdata: random_byte(), tlast: i == op_a - 1};
          tx_q.push_back(beat);
          exp_q.push_back(beat);
        end
        fork
          send_user(name);
          receive_beats(name);
        join
      end
      "R": begin
        blk_start <= 1'b1;
        @(posedge clock);
        blk_start <= 1'b0;
        receive_beats(name);
      end
      "H": begin
        beat = '{tdata: random_byte(), tlast: 1'b1};
        tx_q.push_back(beat);
        exp_q.push_back(beat);
        s_valid <= 1'b1;
        s_beat  <= beat;
        m_ready <= 1'b1;
        repeat (op_a) begin
          @(posedge clock);
          compare(name, 32'd0, {30'b0, s_ready, m_valid});  // Nothing leaks through
        end
        blk_endpt <= USER_ENDPOINT;
        fork
          send_user(name);
          receive_beats(name);
        join
      end
      default: begin
        $display("Unknown command letter in test %0s", name);
        $display("TEST RESULT: FAIL");
        $fatal(1, "bad stimulus file");
      end
    endcase
  endtask

  initial begin
    int fd;
    int code;
    name_t name;
    logic [7:0] cmd;
    logic [31:0] op_a, op_b;
    logic [8*128-1:0] rest;
    logic done;
    clock      = 1'b0;
    areset_n   = 1'b0;
    bus_reset  = 1'b0;
    host_ready = 1'b0;
    blk_start  = 1'b0;
    blk_endpt  = '0;
    state      = '0;
    s_valid    = 1'b0;
    s_beat     = '0;
    m_ready    = 1'b0;
    lfsr_q     = 32'h0adb093d;
    repeat (16) @(posedge clock);
    areset_n <= 1'b1;
    fd = $fopen("testbench/bulk_in_tests.txt", "r");
    if (fd == 0) begin
      $display("Could not open testbench/bulk_in_tests.txt");
      $display("TEST RESULT: FAIL");
      $fatal(1, "missing stimulus file");
    end
    done = 1'b0;
    while (!done) begin
      code = $fscanf(fd, "%s", name);
      if (code != 1) begin
        done = 1'b1;
      end else if (name == "#") begin
        code = $fgets(rest, fd);  // Skip comment line
      end else begin
        code = $fscanf(fd, "%s %h %h", cmd, op_a, op_b);
        run_command(name, cmd, op_a, op_b);
      end
    end
    $fclose(fd);
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/bulk_in_tests.txt
# name command op_a op_b (operands in hex)
# F flags {usb_reset s_ready m_valid blk_in_ready has_telemetry overflow}  W release  B bus reset
reset_flags      F 20 0
reset_release    W 1 0
reset_settle     N 3 0
reset_idle       F 10 0
bus_reset_on     B 1 1
bus_reset_hold   F 20 0
bus_reset_off    B 0 0
bus_reset_settle N 2 0
bus_reset_idle   F 10 0
user_endpoint    E 1 0
user_short       U 5 0
user_long        U 14 0
user_drained     F 10 0
tele_log_a       S 11 2
tele_repeat_a    S 11 1
tele_log_b       S 22 3
tele_log_c       S 33 1
below_threshold  F 12 0
tele_log_d       S 44 2
at_threshold     F 16 0
tele_endpoint    E 2 0
tele_before_read F 06 0
tele_read        X 11 0
tele_read        X 22 0
tele_read        X 33 0
tele_read        X 44 1
tele_read        R 0 0
tele_after_read  F 00 0
overflow_log     L 01 12
overflow_flags   F 07 0
overflow_read    Y 01 10
overflow_read    R 0 0
overflow_after   F 01 0
user_held        H 6 0
user_resumed     F 11 0
user_again       U 8 0
state_clear      S 00 1
final_reset_on   B 1 1
final_reset_off  B 0 0
final_settle     N 2 0
final_idle       F 10 0

// File: sources.f
logic/usb_stream_pkg.sv
logic/telemetry_pkg.sv
logic/reset_sequencer.sv
logic/in_source_select.sv
logic/axis_skid_buffer.sv
logic/telemetry_recorder.sv
logic/bulk_in_bridge.sv
testbench/bulk_in_bridge_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Compile the bulk IN bridge testbench with Verilator and run it.
# The exit status is nonzero when the build or the simulation fails.

set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir

verilator --binary --timing --assert -Wno-fatal \
  -f sources.f \
  --top-module bulk_in_bridge_tb \
  -Mdir "$build_dir" -o bulk_in_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

"./$build_dir/bulk_in_sim"
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit "$status"
fi

echo "Simulation finished cleanly"
exit 0
